// ==== run_sim.sh ====
#!/bin/bash
# Compile and run with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module tb_kernel_ctrl -f verilog.f -o vsim \
  > build.log 2>&1 \
  && ./obj_dir/vsim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null || cat build.log
grep -q "Result: FAILED" sim.log 2>/dev/null && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log 2>/dev/null || { echo "Simulation did not finish"; exit 1; }
exit 0

// ==== source/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

  //////////////////////////////
  // Bus widths

  // Byte address of the register port
  localparam int ADDR_W = 32;

  // One register word per beat
  localparam int DATA_W = 32;

  localparam int STRB_W = DATA_W / 8;  // One strobe per byte

  //////////////////////////////
  // Responses

  // Every access is accepted
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== source/axil_slave_fsm.sv ====
`default_nettype none

module axil_slave_fsm (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic [axil_pkg::ADDR_W-1:0]     awaddr_i,
  input  logic                            awvalid_i,
  input  logic [axil_pkg::DATA_W-1:0]     wdata_i,
  input  logic                            wvalid_i,
  input  logic                            bready_i,
  input  logic [axil_pkg::ADDR_W-1:0]     araddr_i,
  input  logic                            arvalid_i,
  input  logic                            rready_i,
  input  logic [axil_pkg::DATA_W-1:0]     rd_data_i,
  output logic                            awready_o,
  output logic                            wready_o,
  output logic                            bvalid_o,
  output logic [1:0]                      bresp_o,
  output logic                            arready_o,
  output logic                            rvalid_o,
  output logic [axil_pkg::DATA_W-1:0]     rdata_o,
  output logic [1:0]                      rresp_o,
  output logic                            wr_en_o,
  output kernel_regs_pkg::reg_idx_t       wr_idx_o,
  output logic [axil_pkg::DATA_W-1:0]     wr_data_o,
  output kernel_regs_pkg::reg_idx_t       rd_idx_o
);

  logic                            awready_q;
  logic                            wready_q;
  logic                            aw_got_q;
  logic                            w_got_q;
  logic                            bvalid_q;
  logic                            arready_q;
  logic                            rvalid_q;
  kernel_regs_pkg::reg_idx_t       wr_idx_q;
  logic [axil_pkg::DATA_W-1:0]     wr_data_q;
  logic [axil_pkg::DATA_W-1:0]     rdata_q;

  //////////////////////////////
  // Channel state

  always_ff @(posedge clk) begin
    if (!rstn) begin
      awready_q <= 1'b1;
      wready_q  <= 1'b1;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      bvalid_q  <= 1'b0;
      arready_q <= 1'b1;
      rvalid_q  <= 1'b0;
    end else begin
      // Address and data in either order
      if (awready_q && awvalid_i) begin
        awready_q <= 1'b0;
        aw_got_q  <= 1'b1;
      end
      if (wready_q && wvalid_i) begin
        wready_q <= 1'b0;
        w_got_q  <= 1'b1;
      end
      if (aw_got_q && w_got_q) begin  // Write strobe cycle
        bvalid_q <= 1'b1;
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end
      if (bvalid_q && bready_i) begin  // Reopen AW and W
        bvalid_q  <= 1'b0;
        awready_q <= 1'b1;
        wready_q  <= 1'b1;
      end

      if (arready_q && arvalid_i) begin
        arready_q <= 1'b0;
        rvalid_q  <= 1'b1;
      end
      if (rvalid_q && rready_i) begin
        rvalid_q  <= 1'b0;
        arready_q <= 1'b1;
      end
    end
  end

  // Captured address, data and read word
  always_ff @(posedge clk) begin
    if (awready_q && awvalid_i)
      wr_idx_q <= awaddr_i[kernel_regs_pkg::IDX_LSB +: kernel_regs_pkg::IDX_W];
    if (wready_q && wvalid_i)
      wr_data_q <= wdata_i;
    if (arready_q && arvalid_i)
      rdata_q <= rd_data_i;
  end

  assign rd_idx_o  = araddr_i[kernel_regs_pkg::IDX_LSB +: kernel_regs_pkg::IDX_W];

  assign wr_en_o   = aw_got_q && w_got_q;
  assign wr_idx_o  = wr_idx_q;
  assign wr_data_o = wr_data_q;

  assign awready_o = awready_q;
  assign wready_o  = wready_q;
  assign bvalid_o  = bvalid_q;
  assign bresp_o   = axil_pkg::RESP_OKAY;
  assign arready_o = arready_q;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign rresp_o   = axil_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// ==== source/kernel_ctrl_top.sv ====
`default_nettype none

module kernel_ctrl_top #(
  parameter int unsigned WDT_TIMEOUT   = 50_000_000,
  parameter int unsigned WDT_PULSE_LEN = 100_000
) (
  input  logic                            clk,
  input  logic                            rstn,
  // AXI-lite slave
  input  logic [axil_pkg::ADDR_W-1:0]     awaddr_i,
  input  logic                            awvalid_i,
  output logic                            awready_o,
  input  logic [axil_pkg::DATA_W-1:0]     wdata_i,
  input  logic [axil_pkg::STRB_W-1:0]     wstrb_i,  // Full words only
  input  logic                            wvalid_i,
  output logic                            wready_o,
  output logic                            bvalid_o,
  output logic [1:0]                      bresp_o,
  input  logic                            bready_i,
  input  logic [axil_pkg::ADDR_W-1:0]     araddr_i,
  input  logic                            arvalid_i,
  output logic                            arready_o,
  output logic                            rvalid_o,
  output logic [axil_pkg::DATA_W-1:0]     rdata_o,
  output logic [1:0]                      rresp_o,
  input  logic                            rready_i,
  // Engine status
  input  logic [axil_pkg::DATA_W-1:0]     state0_i,
  input  logic [axil_pkg::DATA_W-1:0]     state1_i,
  input  logic [axil_pkg::DATA_W-1:0]     state2_i,
  input  logic [axil_pkg::DATA_W-1:0]     state3_i,
  input  logic                            switch_button_i,
  // Command port
  output logic                            cmd_valid_o,
  output logic [axil_pkg::DATA_W-1:0]     cmd_opcode_o,
  output logic [axil_pkg::DATA_W-1:0]     cmd_data0_o,
  output logic [axil_pkg::DATA_W-1:0]     cmd_data1_o,
  output logic                            sys_reset_o
);

  logic                            wr_en;
  kernel_regs_pkg::reg_idx_t       wr_idx;
  logic [axil_pkg::DATA_W-1:0]     wr_data;
  kernel_regs_pkg::reg_idx_t       rd_idx;
  logic [axil_pkg::DATA_W-1:0]     rd_data;
  logic                            cmd_new;
  logic [axil_pkg::DATA_W-1:0]     delay_cycles;
  logic                            wdt_clear;
  logic                            wdt_enable;
  logic                            wdt_reset;
  logic                            sys_reset_q;

  axil_slave_fsm u_axil_slave_fsm (
    .clk       (clk),
    .rstn      (rstn),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .wdata_i   (wdata_i),
    .wvalid_i  (wvalid_i),
    .bready_i  (bready_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .rready_i  (rready_i),
    .rd_data_i (rd_data),
    .awready_o (awready_o),
    .wready_o  (wready_o),
    .bvalid_o  (bvalid_o),
    .bresp_o   (bresp_o),
    .arready_o (arready_o),
    .rvalid_o  (rvalid_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .wr_en_o   (wr_en),
    .wr_idx_o  (wr_idx),
    .wr_data_o (wr_data),
    .rd_idx_o  (rd_idx)
  );

  kernel_reg_file u_kernel_reg_file (
    .clk          (clk),
    .rstn         (rstn),
    .wr_en_i      (wr_en),
    .wr_idx_i     (wr_idx),
    .wr_data_i    (wr_data),
    .rd_idx_i     (rd_idx),
    .state0_i     (state0_i),
    .state1_i     (state1_i),
    .state2_i     (state2_i),
    .state3_i     (state3_i),
    .rd_data_o    (rd_data),
    .cmd_new_o    (cmd_new),
    .opcode_o     (cmd_opcode_o),
    .data0_o      (cmd_data0_o),
    .data1_o      (cmd_data1_o),
    .delay_o      (delay_cycles),
    .wdt_clear_o  (wdt_clear),
    .wdt_enable_o (wdt_enable)
  );

  launch_delay_counter u_launch_delay_counter (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_new_i   (cmd_new),
    .delay_i     (delay_cycles),
    .cmd_valid_o (cmd_valid_o)
  );

  watchdog_timer #(
    .WDT_TIMEOUT   (WDT_TIMEOUT),
    .WDT_PULSE_LEN (WDT_PULSE_LEN)
  ) u_watchdog_timer (
    .clk         (clk),
    .rstn        (rstn),
    .enable_i    (wdt_enable),
    .clear_i     (wdt_clear),
    .reset_req_o (wdt_reset)
  );

  //////////////////////////////
  // System reset, watchdog or button

  always_ff @(posedge clk) begin
    if (!rstn)
      sys_reset_q <= 1'b0;
    else
      sys_reset_q <= wdt_reset | switch_button_i;
  end

  assign sys_reset_o = sys_reset_q;

endmodule

`default_nettype wire

// ==== source/kernel_reg_file.sv ====
`default_nettype none

module kernel_reg_file (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            wr_en_i,
  input  kernel_regs_pkg::reg_idx_t       wr_idx_i,
  input  logic [axil_pkg::DATA_W-1:0]     wr_data_i,
  input  kernel_regs_pkg::reg_idx_t       rd_idx_i,
  input  logic [axil_pkg::DATA_W-1:0]     state0_i,
  input  logic [axil_pkg::DATA_W-1:0]     state1_i,
  input  logic [axil_pkg::DATA_W-1:0]     state2_i,
  input  logic [axil_pkg::DATA_W-1:0]     state3_i,
  output logic [axil_pkg::DATA_W-1:0]     rd_data_o,
  output logic                            cmd_new_o,
  output logic [axil_pkg::DATA_W-1:0]     opcode_o,
  output logic [axil_pkg::DATA_W-1:0]     data0_o,
  output logic [axil_pkg::DATA_W-1:0]     data1_o,
  output logic [axil_pkg::DATA_W-1:0]     delay_o,
  output logic                            wdt_clear_o,
  output logic                            wdt_enable_o
);

  logic [axil_pkg::DATA_W-1:0] kregs [kernel_regs_pkg::REG_NUM];
  logic                        cmd_new_q;
  logic                        wdt_clear_q;
  logic                        wdt_enable_q;

  // Argument words
  always_ff @(posedge clk) begin
    if (!rstn)
      kregs[kernel_regs_pkg::REG_CMD] <= kernel_regs_pkg::CMD_RESET_VAL;
    else if (wr_en_i)
      kregs[wr_idx_i] <= wr_data_i;
  end

  //////////////////////////////
  // Control bits

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cmd_new_q    <= 1'b0;
      wdt_clear_q  <= 1'b0;
      wdt_enable_q <= 1'b0;
    end else begin
      cmd_new_q <= wr_en_i && (wr_idx_i == kernel_regs_pkg::REG_CMD);  // One cycle
      if (wr_en_i && (wr_idx_i == kernel_regs_pkg::REG_WDT_CLEAR))
        wdt_clear_q <= wr_data_i[0];
      if (wr_en_i && (wr_idx_i == kernel_regs_pkg::REG_WDT_ENABLE))
        wdt_enable_q <= wr_data_i[0];
    end
  end

  // Read-back word
  always_comb begin
    case (rd_idx_i)
      kernel_regs_pkg::REG_CMD: rd_data_o = kregs[kernel_regs_pkg::REG_CMD];
      3'd1:    rd_data_o = state0_i;  // Status words from the engine
      3'd2:    rd_data_o = state1_i;
      3'd3:    rd_data_o = state2_i;
      3'd4:    rd_data_o = state3_i;
      default: rd_data_o = '0;
    endcase
  end

  assign opcode_o     = kregs[kernel_regs_pkg::REG_OPCODE];
  assign data0_o      = kregs[kernel_regs_pkg::REG_DATA0];
  assign data1_o      = kregs[kernel_regs_pkg::REG_DATA1];
  assign delay_o      = kregs[kernel_regs_pkg::REG_DELAY];

  assign cmd_new_o    = cmd_new_q;
  assign wdt_clear_o  = wdt_clear_q;
  assign wdt_enable_o = wdt_enable_q;

endmodule

`default_nettype wire

// ==== source/kernel_regs_pkg.sv ====
`default_nettype none

package kernel_regs_pkg;

  //////////////////////////////
  // Bank geometry

  localparam int REG_NUM = 8;
  localparam int IDX_W   = $clog2(REG_NUM);
  localparam int IDX_LSB = 2;  // Word aligned

  typedef logic [IDX_W-1:0] reg_idx_t;

  //////////////////////////////
  // Register map

  localparam reg_idx_t REG_CMD        = 3'd0;  // Write starts a launch
  localparam reg_idx_t REG_OPCODE     = 3'd1;
  localparam reg_idx_t REG_DATA0      = 3'd2;
  localparam reg_idx_t REG_DATA1      = 3'd3;
  localparam reg_idx_t REG_DELAY      = 3'd4;  // Launch delay in cycles
  localparam reg_idx_t REG_WDT_CLEAR  = 3'd5;  // Bit 0 only
  localparam reg_idx_t REG_WDT_ENABLE = 3'd6;  // Bit 0 only

  // Index 7 is plain spare storage

  //////////////////////////////
  // Reset values

  localparam logic [axil_pkg::DATA_W-1:0] CMD_RESET_VAL = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

// ==== source/launch_delay_counter.sv ====
`default_nettype none

module launch_delay_counter (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            cmd_new_i,
  input  logic [axil_pkg::DATA_W-1:0]     delay_i,
  output logic                            cmd_valid_o
);

  logic                        armed_q;
  logic [axil_pkg::DATA_W-1:0] cnt_q;
  logic                        fire;

  assign fire = armed_q && (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      armed_q <= 1'b0;
    end else if (cmd_new_i) begin
      armed_q <= 1'b1;  // New command restarts the countdown
    end else if (fire) begin
      armed_q <= 1'b0;
    end
  end

  // Countdown value
  always_ff @(posedge clk) begin
    if (cmd_new_i)
      cnt_q <= delay_i;
    else if (armed_q && !fire)
      cnt_q <= cnt_q - 1'b1;
  end

  assign cmd_valid_o = fire;

endmodule

`default_nettype wire

// ==== source/watchdog_timer.sv ====
`default_nettype none

module watchdog_timer #(
  parameter int unsigned WDT_TIMEOUT   = 50_000_000,
  parameter int unsigned WDT_PULSE_LEN = 100_000
) (
  input  logic clk,
  input  logic rstn,
  input  logic enable_i,
  input  logic clear_i,
  output logic reset_req_o
);

  localparam int CNT_W = $clog2(WDT_TIMEOUT);
  localparam int PLS_W = $clog2(WDT_PULSE_LEN + 1);

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WDT_TIMEOUT - 1);
  localparam logic [PLS_W-1:0] PLS_LOAD = PLS_W'(WDT_PULSE_LEN);

  logic [CNT_W-1:0] cnt_q;
  logic [PLS_W-1:0] pulse_q;

  //////////////////////////////
  // Period and pulse counters

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt_q   <= '0;
      pulse_q <= '0;
    end else if (pulse_q != '0) begin
      pulse_q <= pulse_q - 1'b1;
      cnt_q   <= '0;  // Held during the pulse
    end else if (enable_i && !clear_i) begin
      if (cnt_q == CNT_LAST) begin
        cnt_q   <= '0;
        pulse_q <= PLS_LOAD;  // Timeout, start reset pulse
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else begin
      cnt_q <= '0;
    end
  end

  assign reset_req_o = (pulse_q != '0);

endmodule

`default_nettype wire

// ==== test/kernel_ctrl_sva.sv ====
`default_nettype none

module kernel_ctrl_sva #(
  parameter int unsigned PULSE_LEN = 6
) (
  input wire logic        clk,
  input wire logic        rstn,
  input wire logic        bvalid_o,
  input wire logic        bready_i,
  input wire logic        arready_o,
  input wire logic        rvalid_o,
  input wire logic        rready_i,
  input wire logic [31:0] rdata_o,
  input wire logic        cmd_new,
  input wire logic [31:0] delay_cycles,
  input wire logic        cmd_valid_o,
  input wire logic        wdt_clear,
  input wire logic        wdt_reset,
  input wire logic        switch_button_i,
  input wire logic        sys_reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;  // Read by the testbench
  logic        pending_q;
  logic [32:0] since_q;
  logic [32:0] due_q;
  int unsigned run_q;

  // Cycles since the command strobe, launch due at D+1
  always_ff @(posedge clk) begin
    if (!rstn) begin
      pending_q <= 1'b0;
      since_q   <= '0;
      due_q     <= '0;
    end else if (cmd_new) begin
      pending_q <= 1'b1;
      since_q   <= 33'd1;
      due_q     <= {1'b0, delay_cycles} + 33'd1;
    end else begin
      since_q <= since_q + 1'b1;
      if (since_q == due_q)
        pending_q <= 1'b0;
    end
  end

  // Length of the current watchdog pulse
  always_ff @(posedge clk) begin
    if (!rstn || !wdt_reset)
      run_q <= 0;
    else
      run_q <= run_q + 1;
  end

  ////////////////////////////////
  // Launch and reset timing

  cmd_with_b: assert property (@(posedge clk) disable iff (!rstn)
    cmd_new |-> $rose(bvalid_o))
    else begin
      fail_cnt++;
      $error("command strobe not aligned with bvalid_o");
    end

  launch_time: assert property (@(posedge clk) disable iff (!rstn)
    cmd_valid_o == (pending_q && since_q == due_q))
    else begin
      fail_cnt++;
      $error("cmd_valid_o out of step with the delay");
    end

  pulse_width: assert property (@(posedge clk) disable iff (!rstn)
    $fell(wdt_reset) |-> run_q == PULSE_LEN)
    else begin
      fail_cnt++;
      $error("watchdog pulse has the wrong width");
    end

  reset_follow: assert property (@(posedge clk) disable iff (!rstn)
    $past(rstn) |-> sys_reset_o == $past(wdt_reset | switch_button_i))
    else begin
      fail_cnt++;
      $error("sys_reset_o does not follow its sources");
    end

  button_reset: assert property (@(posedge clk) disable iff (!rstn)
    switch_button_i |=> sys_reset_o)
    else begin
      fail_cnt++;
      $error("button did not raise sys_reset_o");
    end

  cleared_quiet: assert property (@(posedge clk) disable iff (!rstn)
    wdt_clear && !wdt_reset |=> !wdt_reset)
    else begin
      fail_cnt++;
      $error("cleared watchdog fired");
    end

  ////////////////////////////////
  // Handshake rules

  b_hold: assert property (@(posedge clk) disable iff (!rstn)
    bvalid_o && !bready_i |=> bvalid_o)
    else begin
      fail_cnt++;
      $error("bvalid_o dropped without bready");
    end

  r_hold: assert property (@(posedge clk) disable iff (!rstn)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
    else begin
      fail_cnt++;
      $error("read response changed before rready");
    end

  ar_closed: assert property (@(posedge clk) disable iff (!rstn)
    !(arready_o && rvalid_o))
    else begin
      fail_cnt++;
      $error("arready_o high while a read is pending");
    end

endmodule

bind kernel_ctrl_top kernel_ctrl_sva #(.PULSE_LEN(WDT_PULSE_LEN)) sva_i (
  .clk             (clk),
  .rstn            (rstn),
  .bvalid_o        (bvalid_o),
  .bready_i        (bready_i),
  .arready_o       (arready_o),
  .rvalid_o        (rvalid_o),
  .rready_i        (rready_i),
  .rdata_o         (rdata_o),
  .cmd_new         (cmd_new),
  .delay_cycles    (delay_cycles),
  .cmd_valid_o     (cmd_valid_o),
  .wdt_clear       (wdt_clear),
  .wdt_reset       (wdt_reset),
  .switch_button_i (switch_button_i),
  .sys_reset_o     (sys_reset_o)
);

`default_nettype wire

// ==== test/tb_kernel_ctrl.sv ====
`default_nettype none

module tb_kernel_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  // About 40 bus transfers and four watchdog periods fit well inside
  localparam int MAX_CYCLES = 3000;

  logic        clk = 1'b0;
  logic        rstn;
  logic [31:0] awaddr_i, wdata_i, araddr_i, rdata_o;
  logic [3:0]  wstrb_i;
  logic        awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
  logic        awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  logic [1:0]  bresp_o, rresp_o;
  logic [31:0] state0_i, state1_i, state2_i, state3_i;
  logic        switch_button_i;
  logic        cmd_valid_o, sys_reset_o;
  logic [31:0] cmd_opcode_o, cmd_data0_o, cmd_data1_o;
  integer      seed = 32'h5d6a_d951;
  int          cycle_cnt = 0;
  int          launch_cnt = 0;
  logic [31:0] seen_opcode, seen_data0, seen_data1;
  logic [31:0] word;
  logic [31:0] stored [8];

  kernel_ctrl_top #(.WDT_TIMEOUT(40), .WDT_PULSE_LEN(6)) dut_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run exceeded %0d cycles, the DUT stopped responding", MAX_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end else if (dut_i.sva_i.fail_cnt != 0) begin
      $display("A bound assertion failed");
      $display("Result: FAILED");
      $fatal(1, "assertion");
    end
  end

  // Command fields as they leave with the launch pulse
  always @(posedge clk) begin
    if (cmd_valid_o) begin
      launch_cnt++;
      seen_opcode = cmd_opcode_o;
      seen_data0  = cmd_data0_o;
      seen_data1  = cmd_data1_o;
    end
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic write_reg(input int idx, input logic [31:0] data);
    int  gap_aw, gap_w, cyc, hold;
    bit  aw_done, w_done;
    gap_aw  = $random(seed) & 3;  // Random order of AW and W
    gap_w   = $random(seed) & 3;
    hold    = $random(seed) & 3;
    aw_done = 0;
    w_done  = 0;
    cyc     = 0;
    awaddr_i = 32'(idx) << 2;
    wdata_i  = data;
    while (!(aw_done && w_done)) begin
      awvalid_i = !aw_done && cyc >= gap_aw;
      wvalid_i  = !w_done && cyc >= gap_w;
      @(posedge clk);
      if (awvalid_i && awready_o) aw_done = 1;
      if (wvalid_i && wready_o) w_done = 1;
      #1;
      cyc++;
    end
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    while (!bvalid_o) begin
      @(posedge clk);
      #1;
    end
    repeat (hold) @(posedge clk);  // Back-pressure on B
    #1 bready_i = 1'b1;
    @(posedge clk);
    check_eq("write_resp", 32'd0, {30'd0, bresp_o});
    #1 bready_i = 1'b0;
  endtask

  task automatic read_reg(input int idx, output logic [31:0] data);
    int gap, hold;
    gap  = $random(seed) & 3;
    hold = $random(seed) & 3;
    repeat (gap) @(posedge clk);
    #1 araddr_i = 32'(idx) << 2;
    arvalid_i = 1'b1;
    do @(posedge clk); while (!arready_o);
    #1 arvalid_i = 1'b0;
    repeat (hold) @(posedge clk);  // Back-pressure on R
    #1 rready_i = 1'b1;
    do @(posedge clk); while (!rvalid_o);
    data = rdata_o;
    check_eq("read_resp", 32'd0, {30'd0, rresp_o});
    #1 rready_i = 1'b0;
  endtask

  task automatic wait_reset_edge(input bit level, input int limit);
    int n;
    n = 0;
    while (sys_reset_o !== level && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (sys_reset_o !== level) begin
      $display("sys_reset_o never reached %0d", level);
      $display("Result: FAILED");
      $fatal(1, "watchdog");
    end
  endtask

  task automatic launch(input logic [31:0] tag, input logic [31:0] delay);
    int n;
    int start;
    stored[1] = $random(seed);
    stored[2] = $random(seed);
    stored[3] = $random(seed);
    write_reg(1, stored[1]);
    write_reg(2, stored[2]);
    write_reg(3, stored[3]);
    write_reg(4, delay);
    start = launch_cnt;
    write_reg(0, tag);
    n = 0;
    while (launch_cnt == start && n < 20) begin
      @(posedge clk);
      #1;
      n++;
    end
    check_eq("launch_count", start + 1, launch_cnt);
    check_eq("launch_opcode", stored[1], seen_opcode);
    check_eq("launch_data0", stored[2], seen_data0);
    check_eq("launch_data1", stored[3], seen_data1);
    @(posedge clk);
    #1;
  endtask

  initial begin
    rstn = 1'b0;
    {awaddr_i, wdata_i, araddr_i} = '0;
    wstrb_i = 4'hF;
    {awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i} = '0;
    state0_i = 32'h1111_0001;
    state1_i = 32'h2222_0002;
    state2_i = 32'h3333_0003;
    state3_i = 32'h4444_0004;
    switch_button_i = 1'b0;
    repeat (4) @(posedge clk);
    #1 rstn = 1'b1;

    //////////////////////////////
    // Reset values
    check_eq("reset_outputs", 32'h70, {25'd0, awready_o, wready_o, arready_o,
                                       bvalid_o, rvalid_o, cmd_valid_o, sys_reset_o});
    read_reg(0, word);
    check_eq("reset_cmd", 32'hDEAD_BEEF, word);

    // Storage and read-back map
    foreach (stored[i]) stored[i] = $random(seed);
    write_reg(1, stored[1]);
    write_reg(2, stored[2]);
    write_reg(3, stored[3]);
    write_reg(7, stored[7]);
    write_reg(5, 32'hFFFF_FFFF);  // Clear set, enable off
    write_reg(6, 32'hFFFF_FFFE);
    read_reg(1, word);
    check_eq("read_state0", state0_i, word);
    read_reg(2, word);
    check_eq("read_state1", state1_i, word);
    read_reg(3, word);
    check_eq("read_state2", state2_i, word);
    read_reg(4, word);
    check_eq("read_state3", state3_i, word);
    for (int i = 5; i < 8; i++) begin
      read_reg(i, word);
      check_eq("read_zero", 32'd0, word);
    end

    //////////////////////////////
    // Launches with D = 0 and D = 5
    launch(32'hC0DE_0001, 32'd0);
    launch(32'hC0DE_0002, 32'd5);
    read_reg(0, word);
    check_eq("read_cmd", 32'hC0DE_0002, word);

    // Watchdog runs free twice, then is cleared
    write_reg(5, 32'd0);
    write_reg(6, 32'd1);
    wait_reset_edge(1'b1, 60);
    wait_reset_edge(1'b0, 20);
    wait_reset_edge(1'b1, 60);
    write_reg(5, 32'd1);
    wait_reset_edge(1'b0, 20);
    repeat (100) begin
      @(posedge clk);
      #1;
      check_eq("wdt_cleared", 32'd0, {31'd0, sys_reset_o});
    end
    write_reg(6, 32'd0);
    write_reg(5, 32'd0);

    //////////////////////////////
    // Button
    #1 switch_button_i = 1'b1;
    repeat (2) @(posedge clk);
    #1 switch_button_i = 1'b0;
    repeat (4) @(posedge clk);

    if (dut_i.sva_i.fail_cnt == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1, "assertion");
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/axil_pkg.sv
source/kernel_regs_pkg.sv
source/axil_slave_fsm.sv
source/kernel_reg_file.sv
source/launch_delay_counter.sv
source/watchdog_timer.sv
source/kernel_ctrl_top.sv
test/kernel_ctrl_sva.sv
test/tb_kernel_ctrl.sv
